// ==== logic/sq_pkg.sv ====
package sq_pkg;

    // Function code: bit 2 marks the unsigned variants, bits 1:0 give the size
    typedef logic [2:0] mem_func_t;
    typedef logic [1:0] mem_size_t;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // Queue index, enough for up to 16 slots
    typedef logic [3:0] sq_idx_t;

    localparam mem_size_t size_byte = 2'd0;
    localparam mem_size_t size_half = 2'd1;
    localparam mem_size_t size_word = 2'd2;

    localparam mem_func_t mem_byte  = 3'b000;
    localparam mem_func_t mem_half  = 3'b001;
    localparam mem_func_t mem_word  = 3'b010;
    localparam mem_func_t mem_byteu = 3'b100;
    localparam mem_func_t mem_halfu = 3'b101;

    // Depth of the data cache array in words
    localparam int dcache_words = 256;

    // One data word seen as byte lanes or as half lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

    function automatic mem_size_t func_size(mem_func_t func);
        return func[1:0];
    endfunction

    // Circular index step, slots is the physical queue length
    function automatic sq_idx_t sq_wrap(sq_idx_t base, int unsigned step, int unsigned slots);
        int unsigned sum;
        sum = base + step;
        if (sum >= slots)
            sum = sum - slots;
        return sq_idx_t'(sum);
    endfunction

    // Places the low bytes of data into the lanes that offset and size select
    function automatic data_t lane_merge(data_t base, data_t data, logic [1:0] offset,
                                         mem_size_t size);
        mem_word_u merged;
        mem_word_u src;
        merged = base;
        src = data;
        case (size)
            size_byte: merged.bytes[offset] = src.bytes[0];
            size_half: merged.halves[offset[1]] = src.halves[0];
            default:   merged = src;
        endcase
        return merged;
    endfunction

endpackage

// ==== logic/store_queue.sv ====
module store_queue
    import sq_pkg::*;
#(
    parameter int sq_len         = 8,
    parameter int dispatch_width = 2,
    parameter int store_ports    = 2,
    parameter int drain_width    = 2,
    localparam int slots         = sq_len + 1,
    localparam int sent_w        = $clog2(drain_width + 1)
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic      [dispatch_width-1:0] alloc_valid,
    input  mem_func_t [dispatch_width-1:0] alloc_func,
    input  logic      [store_ports-1:0]    exec_valid,
    input  addr_t     [store_ports-1:0]    exec_base,
    input  logic      [store_ports-1:0][11:0] exec_imm,
    input  data_t     [store_ports-1:0]    exec_data,
    input  sq_idx_t   [store_ports-1:0]    exec_idx,
    input  sq_idx_t                        pending_commits,
    input  logic      [drain_width-1:0]    wr_accept,
    output logic                           almost_full,
    output sq_idx_t                        head,
    output sq_idx_t                        tail,
    output sq_idx_t                        tail_ready,
    output logic      [sent_w-1:0]         sent_count,
    output logic      [drain_width-1:0]    wr_valid,
    output addr_t     [drain_width-1:0]    wr_addr,
    output mem_func_t [drain_width-1:0]    wr_func,
    output data_t     [drain_width-1:0]    wr_data,
    output logic      [slots-1:0]          entry_valid,
    output logic      [slots-1:0]          entry_ready,
    output addr_t     [slots-1:0]          entry_addr,
    output data_t     [slots-1:0]          entry_data,
    output mem_func_t [slots-1:0]          entry_func
);

    sq_idx_t size;
    logic [slots-1:0] entry_accepted;

    // Execute results, one cycle behind the ports
    logic    [store_ports-1:0] fill_valid;
    addr_t   [store_ports-1:0] fill_addr;
    data_t   [store_ports-1:0] fill_data;
    sq_idx_t [store_ports-1:0] fill_idx;

    sq_idx_t next_head;
    sq_idx_t next_tail;
    sq_idx_t next_size;
    logic      [slots-1:0] next_valid;
    logic      [slots-1:0] next_ready;
    logic      [slots-1:0] next_accepted;
    addr_t     [slots-1:0] next_addr;
    data_t     [slots-1:0] next_data;
    mem_func_t [slots-1:0] next_func;

    // Keeps room for a full dispatch group
    assign almost_full = int'(size) > sq_len - dispatch_width;

    always_ff @(posedge clock) begin
        if (reset) begin
            fill_valid <= '0;
        end else begin
            fill_valid <= exec_valid;
        end
    end

    always_ff @(posedge clock) begin
        for (int p = 0; p < store_ports; p++) begin
            fill_addr[p] <= exec_base[p] + {{20{exec_imm[p][11]}}, exec_imm[p]};
            fill_data[p] <= exec_data[p];
            fill_idx[p]  <= exec_idx[p];
        end
    end

    // Offer committed ready stores from head, stopping at the first gap
    always_comb begin
        sq_idx_t idx;
        logic chain;
        wr_valid = '0;
        wr_addr  = '0;
        wr_func  = '0;
        wr_data  = '0;
        chain    = 1'b1;
        for (int i = 0; i < drain_width; i++) begin
            idx = sq_wrap(head, i, slots);
            chain = chain && (i < int'(pending_commits)) && entry_valid[idx]
                    && entry_ready[idx] && !entry_accepted[idx];
            wr_valid[i] = chain;
            wr_addr[i]  = entry_addr[idx];
            wr_func[i]  = entry_func[idx];
            wr_data[i]  = entry_data[idx];
        end
    end

    always_comb begin
        sq_idx_t idx;
        logic stop;
        next_head     = head;
        next_tail     = tail;
        next_size     = size;
        next_valid    = entry_valid;
        next_ready    = entry_ready;
        next_accepted = entry_accepted;
        next_addr     = entry_addr;
        next_data     = entry_data;
        next_func     = entry_func;
        sent_count    = '0;

        // Allocation in lane order at tail
        if (!almost_full) begin
            for (int i = 0; i < dispatch_width; i++) begin
                if (alloc_valid[i]) begin
                    next_valid[next_tail]    = 1'b1;
                    next_ready[next_tail]    = 1'b0;
                    next_accepted[next_tail] = 1'b0;
                    next_addr[next_tail]     = '0;
                    next_data[next_tail]     = '0;
                    next_func[next_tail]     = alloc_func[i];
                    next_tail = sq_wrap(next_tail, 1, slots);
                    next_size = next_size + 1'b1;
                end
            end
        end

        for (int p = 0; p < store_ports; p++) begin
            if (fill_valid[p]) begin
                next_ready[fill_idx[p]] = 1'b1;
                next_addr[fill_idx[p]]  = fill_addr[p];
                next_data[fill_idx[p]]  = fill_data[p];
            end
        end

        // Retire in order; an accept behind a refused lane is only remembered
        stop = 1'b0;
        for (int i = 0; i < drain_width; i++) begin
            idx = sq_wrap(head, i, slots);
            if (wr_accept[i] || (entry_valid[idx] && entry_accepted[idx])) begin
                if (stop) begin
                    next_accepted[idx] = 1'b1;
                end else begin
                    next_valid[idx]    = 1'b0;
                    next_ready[idx]    = 1'b0;
                    next_accepted[idx] = 1'b0;
                    next_head  = sq_wrap(next_head, 1, slots);
                    next_size  = next_size - 1'b1;
                    sent_count = sent_count + 1'b1;
                end
            end else begin
                stop = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head           <= '0;
            tail           <= '0;
            size           <= '0;
            entry_valid    <= '0;
            entry_ready    <= '0;
            entry_accepted <= '0;
            entry_addr     <= '0;
            entry_data     <= '0;
            entry_func     <= '0;
        end else begin
            head           <= next_head;
            tail           <= next_tail;
            size           <= next_size;
            entry_valid    <= next_valid;
            entry_ready    <= next_ready;
            entry_accepted <= next_accepted;
            entry_addr     <= next_addr;
            entry_data     <= next_data;
            entry_func     <= next_func;
        end
    end

    // End of the ready run starting at head
    always_comb begin
        sq_idx_t idx;
        logic run;
        int unsigned count;
        run   = 1'b1;
        count = 0;
        for (int i = 0; i < sq_len; i++) begin
            idx = sq_wrap(head, i, slots);
            run = run && entry_valid[idx] && entry_ready[idx];
            if (run) begin
                count = count + 1;
            end
        end
        tail_ready = sq_wrap(head, count, slots);
    end

endmodule

// ==== logic/store_forward.sv ====
module store_forward
    import sq_pkg::*;
#(
    parameter int sq_len = 8,
    localparam int slots = sq_len + 1
) (
    input  sq_idx_t                head,
    input  logic      [slots-1:0]  entry_valid,
    input  logic      [slots-1:0]  entry_ready,
    input  addr_t     [slots-1:0]  entry_addr,
    input  data_t     [slots-1:0]  entry_data,
    input  mem_func_t [slots-1:0]  entry_func,
    input  addr_t                  load_addr,
    input  mem_func_t              load_func,
    input  sq_idx_t                load_tail_store,
    input  data_t                  rd_data,
    output addr_t                  rd_addr,
    output data_t                  load_data,
    output logic                   load_forwarded
);

    localparam int index_bits = $clog2(dcache_words);

    // Word aligned, limited to the range the cache array decodes
    assign rd_addr = {{(30 - index_bits){1'b0}}, load_addr[index_bits+1:2], 2'b00};

    // Store fully covers the bytes of the load
    function automatic logic covers(mem_size_t st_size, addr_t st_addr,
                                    mem_size_t ld_size, addr_t ld_addr);
        case (st_size)
            size_byte: return ld_size == size_byte && st_addr == ld_addr;
            size_half: return ld_size != size_word && st_addr[31:1] == ld_addr[31:1];
            default:   return st_addr[31:2] == ld_addr[31:2];
        endcase
    endfunction

    always_comb begin
        sq_idx_t idx;
        sq_idx_t win;
        logic reached;
        logic hit;
        reached = 1'b0;
        hit     = 1'b0;
        win     = head;
        // Later matches overwrite earlier ones, so the youngest older store wins
        for (int j = 0; j < sq_len; j++) begin
            idx = sq_wrap(head, j, slots);
            reached = reached || (idx == load_tail_store);
            if (!reached && entry_valid[idx] && entry_ready[idx]
                    && covers(func_size(entry_func[idx]), entry_addr[idx],
                              func_size(load_func), load_addr)) begin
                hit = 1'b1;
                win = idx;
            end
        end

        load_forwarded = hit;
        if (hit) begin
            load_data = lane_merge('0, entry_data[win], entry_addr[win][1:0],
                                   func_size(entry_func[win]));
        end else begin
            load_data = rd_data;
        end
    end

endmodule

// ==== logic/commit_tracker.sv ====
module commit_tracker #(
    parameter int drain_width = 2,
    localparam int count_w    = 4,
    localparam int sent_w     = $clog2(drain_width + 1)
) (
    input  logic               clock,
    input  logic               reset,
    input  logic [count_w-1:0] commit_count,
    input  logic [sent_w-1:0]  sent_count,
    output logic [count_w-1:0] pending_commits
);

    logic [count_w-1:0] next_pending;

    // Committed stores arrive from the ROB, drained ones leave through the queue
    always_comb begin
        next_pending = pending_commits + commit_count;
        next_pending = next_pending - sent_count;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pending_commits <= '0;
        end else begin
            pending_commits <= next_pending;
        end
    end

endmodule

// ==== logic/dcache_store_port.sv ====
module dcache_store_port
    import sq_pkg::*;
#(
    parameter int drain_width = 2
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic      [drain_width-1:0] wr_valid,
    input  addr_t     [drain_width-1:0] wr_addr,
    input  mem_func_t [drain_width-1:0] wr_func,
    input  data_t     [drain_width-1:0] wr_data,
    input  logic                        mem_stall,
    input  addr_t                       rd_addr,
    output logic      [drain_width-1:0] wr_accept,
    output data_t                       rd_data
);

    localparam int index_bits = $clog2(dcache_words);

    data_t mem [dcache_words];
    logic [index_bits-1:0] wr_index [drain_width];
    data_t merged [drain_width];

    assign wr_accept = wr_valid & {drain_width{~mem_stall}};
    assign rd_data   = mem[rd_addr[index_bits+1:2]];

    always_comb begin
        for (int i = 0; i < drain_width; i++) begin
            wr_index[i] = wr_addr[i][index_bits+1:2];
        end
    end

    // Each lane builds on the stored word and on earlier lanes to the same word
    always_comb begin
        for (int i = 0; i < drain_width; i++) begin
            merged[i] = mem[wr_index[i]];
            for (int k = 0; k < i; k++) begin
                if (wr_accept[k] && wr_index[k] == wr_index[i]) begin
                    merged[i] = lane_merge(merged[i], wr_data[k], wr_addr[k][1:0],
                                           func_size(wr_func[k]));
                end
            end
            merged[i] = lane_merge(merged[i], wr_data[i], wr_addr[i][1:0],
                                   func_size(wr_func[i]));
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int w = 0; w < dcache_words; w++) begin
                mem[w] <= '0;
            end
        end else begin
            // Highest lane is written last and wins on a shared word
            for (int i = 0; i < drain_width; i++) begin
                if (wr_accept[i]) begin
                    mem[wr_index[i]] <= merged[i];
                end
            end
        end
    end

endmodule

// ==== logic/store_subsystem.sv ====
module store_subsystem
    import sq_pkg::*;
#(
    parameter int sq_len         = 8,
    parameter int dispatch_width = 2,
    parameter int store_ports    = 2,
    parameter int drain_width    = 2
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic      [dispatch_width-1:0] alloc_valid,
    input  mem_func_t [dispatch_width-1:0] alloc_func,
    input  logic      [store_ports-1:0]    exec_valid,
    input  addr_t     [store_ports-1:0]    exec_base,
    input  logic      [store_ports-1:0][11:0] exec_imm,
    input  data_t     [store_ports-1:0]    exec_data,
    input  sq_idx_t   [store_ports-1:0]    exec_idx,
    input  sq_idx_t                        commit_count,
    input  logic                           mem_stall,
    input  addr_t                          load_addr,
    input  mem_func_t                      load_func,
    input  sq_idx_t                        load_tail_store,
    output data_t                          load_data,
    output logic                           load_forwarded,
    output logic                           almost_full,
    output sq_idx_t                        head,
    output sq_idx_t                        tail,
    output sq_idx_t                        tail_ready
);

    localparam int slots  = sq_len + 1;
    localparam int sent_w = $clog2(drain_width + 1);

    sq_idx_t pending_commits;
    logic [sent_w-1:0] sent_count;

    logic      [drain_width-1:0] wr_valid;
    logic      [drain_width-1:0] wr_accept;
    addr_t     [drain_width-1:0] wr_addr;
    mem_func_t [drain_width-1:0] wr_func;
    data_t     [drain_width-1:0] wr_data;

    logic      [slots-1:0] entry_valid;
    logic      [slots-1:0] entry_ready;
    addr_t     [slots-1:0] entry_addr;
    data_t     [slots-1:0] entry_data;
    mem_func_t [slots-1:0] entry_func;

    addr_t rd_addr;
    data_t rd_data;

    store_queue #(
        .sq_len(sq_len),
        .dispatch_width(dispatch_width),
        .store_ports(store_ports),
        .drain_width(drain_width)
    ) store_queue_i (.*);

    commit_tracker #(
        .drain_width(drain_width)
    ) commit_tracker_i (.*);

    store_forward #(
        .sq_len(sq_len)
    ) store_forward_i (.*);

    dcache_store_port #(
        .drain_width(drain_width)
    ) dcache_store_port_i (.*);

endmodule

// ==== testbench/store_subsystem_checker.sv ====
module store_subsystem_checker
    import sq_pkg::*;
#(
    parameter int dispatch_width = 2,
    parameter int drain_width    = 2,
    localparam int sent_w        = $clog2(drain_width + 1)
) (
    input logic                      clock,
    input logic                      reset,
    input logic [dispatch_width-1:0] alloc_valid,
    input logic                      almost_full,
    input sq_idx_t                   tail,
    input sq_idx_t                   pending_commits,
    input logic [sent_w-1:0]         sent_count,
    input logic [drain_width-1:0]    wr_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // Allocation is refused as a whole while almost full
    no_alloc_when_full: assert property (@(posedge clock) disable iff (reset)
        (almost_full && (|alloc_valid)) |=> tail == $past(tail))
    else begin
        $error("tail moved while almost_full was high");
        fail_count++;
    end

    // Valid write lanes form a run from lane 0
    lanes_contiguous: assert property (@(posedge clock) disable iff (reset)
        (wr_valid & drain_width'(wr_valid + 1'b1)) == '0)
    else begin
        $error("wr_valid lanes are not contiguous: %b", wr_valid);
        fail_count++;
    end

    sent_within_commits: assert property (@(posedge clock) disable iff (reset)
        sent_count <= pending_commits)
    else begin
        $error("sent_count %0d exceeds pending_commits %0d", sent_count, pending_commits);
        fail_count++;
    end

endmodule

bind store_queue store_subsystem_checker #(
    .dispatch_width(dispatch_width),
    .drain_width(drain_width)
) queue_checker_i (
    .clock(clock),
    .reset(reset),
    .alloc_valid(alloc_valid),
    .almost_full(almost_full),
    .tail(tail),
    .pending_commits(pending_commits),
    .sent_count(sent_count),
    .wr_valid(wr_valid)
);

// ==== testbench/store_subsystem_tb.sv ====
module store_subsystem_tb
    import sq_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int sq_len         = 8;
    localparam int dispatch_width = 2;
    localparam int store_ports    = 2;
    localparam int drain_width    = 2;
    localparam int slots          = sq_len + 1;
    // Two rounds of a 256 cycle memory sweep plus about 150 cycles of traffic
    localparam int timeout_cycles = 4000;

    logic clock;
    logic reset;
    logic      [dispatch_width-1:0]    alloc_valid;
    mem_func_t [dispatch_width-1:0]    alloc_func;
    logic      [store_ports-1:0]       exec_valid;
    addr_t     [store_ports-1:0]       exec_base;
    logic      [store_ports-1:0][11:0] exec_imm;
    data_t     [store_ports-1:0]       exec_data;
    sq_idx_t   [store_ports-1:0]       exec_idx;
    sq_idx_t   commit_count;
    sq_idx_t   load_tail_store;
    sq_idx_t   head;
    sq_idx_t   tail;
    sq_idx_t   tail_ready;
    addr_t     load_addr;
    mem_func_t load_func;
    data_t     load_data;
    logic      mem_stall;
    logic      load_forwarded;
    logic      almost_full;

    // Queue slots and cache words as the stimulus expects them
    logic      model_valid [slots];
    logic      model_ready [slots];
    addr_t     model_addr  [slots];
    data_t     model_data  [slots];
    mem_func_t model_func  [slots];
    data_t     model_mem   [dcache_words];
    sq_idx_t   model_head;
    sq_idx_t   model_tail;
    int        model_count;
    int        seed;
    int        cycles = 0;
    logic      load_check;

    store_subsystem #(
        .sq_len(sq_len),
        .dispatch_width(dispatch_width),
        .store_ports(store_ports),
        .drain_width(drain_width)
    ) store_subsystem_i (.*);

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: no verdict after %0d cycles", cycles);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_idx(string name, sq_idx_t got, sq_idx_t expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_word(string name, data_t got, data_t expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_bit(string name, logic got, logic expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    function automatic sq_idx_t step(sq_idx_t idx, int n);
        return sq_idx_t'((int'(idx) + n) % slots);
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic mem_func_t rand_func();
        mem_func_t f;
        f = mem_func_t'(rand_below(3));
        if (f != mem_word && rand_below(2) == 1)
            f[2] = 1'b1;
        return f;
    endfunction

    function automatic addr_t align(addr_t a, mem_func_t f);
        case (f[1:0])
            2'd0:    return a;
            2'd1:    return {a[31:1], 1'b0};
            default: return {a[31:2], 2'b00};
        endcase
    endfunction

    // Store data placed into the byte lanes its address and size select
    function automatic data_t place(data_t base, data_t data, addr_t a, mem_func_t f);
        data_t w;
        w = base;
        case (f[1:0])
            2'd0:    w[8*a[1:0] +: 8] = data[7:0];
            2'd1:    w[16*a[1] +: 16] = data[15:0];
            default: w = data;
        endcase
        return w;
    endfunction

    // Expected load result, bit 32 is the forwarded flag
    function automatic logic [32:0] ref_load(addr_t a, mem_func_t f, sq_idx_t stop);
        sq_idx_t idx;
        logic hit;
        logic match;
        data_t value;
        hit   = 1'b0;
        value = model_mem[a[9:2]];
        idx   = model_head;
        for (int j = 0; j < sq_len && idx != stop; j++) begin
            case (model_func[idx][1:0])
                2'd0:    match = f[1:0] == 2'd0 && model_addr[idx] == a;
                2'd1:    match = f[1:0] != 2'd2 && model_addr[idx][31:1] == a[31:1];
                default: match = model_addr[idx][31:2] == a[31:2];
            endcase
            if (model_valid[idx] && model_ready[idx] && match) begin
                hit   = 1'b1;
                value = place('0, model_data[idx], model_addr[idx], model_func[idx]);
            end
            idx = step(idx, 1);
        end
        return {hit, value};
    endfunction

    function automatic sq_idx_t expect_tail_ready();
        sq_idx_t idx;
        logic run;
        idx = model_head;
        run = 1'b1;
        for (int j = 0; j < sq_len; j++) begin
            run = run && model_valid[idx] && model_ready[idx];
            if (run)
                idx = step(idx, 1);
        end
        return idx;
    endfunction

    always @(negedge clock) begin : compare_load
        logic [32:0] expected;
        if (load_check) begin
            expected = ref_load(load_addr, load_func, load_tail_store);
            check_bit("load_forwarded", load_forwarded, expected[32]);
            check_word("load_data", load_data, expected[31:0]);
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic allocate(logic [dispatch_width-1:0] mask);
        logic full;
        full = model_count > sq_len - dispatch_width;
        check_bit("almost_full", almost_full, full);
        alloc_valid = mask;
        for (int i = 0; i < dispatch_width; i++) begin
            alloc_func[i] = rand_func();
            if (mask[i] && !full) begin
                model_valid[model_tail] = 1'b1;
                model_ready[model_tail] = 1'b0;
                model_func[model_tail]  = alloc_func[i];
                model_tail = step(model_tail, 1);
                model_count++;
            end
        end
        next_cycle();
        alloc_valid = '0;
        check_idx("tail", tail, model_tail);
    endtask

    task automatic fill_queue();
        logic [dispatch_width-1:0] mask;
        while (model_count <= sq_len - dispatch_width) begin
            mask = dispatch_width'(rand_below(1 << dispatch_width));
            if (mask == '0)
                mask[0] = 1'b1;
            allocate(mask);
        end
        // Offers once almost full must leave tail alone
        allocate('1);
        allocate('1);
    endtask

    task automatic set_port(int p, sq_idx_t idx);
        addr_t a;
        addr_t base;
        a    = align(32'h1f0 + rand_below(80), model_func[idx]);
        base = 32'h200 + 4 * rand_below(16);
        exec_valid[p] = 1'b1;
        exec_base[p]  = base;
        exec_imm[p]   = 12'(a - base);
        exec_data[p]  = $random(seed);
        exec_idx[p]   = idx;
        model_addr[idx]  = a;
        model_data[idx]  = exec_data[p];
        model_ready[idx] = 1'b1;
    endtask

    // Register edge, then entry write edge
    task automatic finish_execute();
        next_cycle();
        exec_valid = '0;
        next_cycle();
    endtask

    task automatic forward_loads(int count);
        sq_idx_t pick;
        mem_func_t f;
        load_check = 1'b1;
        repeat (count) begin
            f    = rand_func();
            pick = step(model_head, int'(rand_below(model_count)));
            if (rand_below(4) != 0)
                load_addr = align(model_addr[pick] + rand_below(4), f);
            else
                load_addr = align(32'h1f0 + rand_below(80), f);
            load_func       = f;
            load_tail_store = step(model_head, int'(rand_below(model_count + 1)));
            next_cycle();
        end
        load_check = 1'b0;
    endtask

    task automatic commit_and_drain(logic stall);
        int n;
        logic [7:0] w;
        while (model_count > 0) begin
            n = 1 + int'(rand_below(3));
            if (n > model_count)
                n = model_count;
            commit_count = sq_idx_t'(n);
            mem_stall    = stall && rand_below(2) == 1;
            repeat (n) begin
                w = model_addr[model_head][9:2];
                model_mem[w] = place(model_mem[w], model_data[model_head],
                                     model_addr[model_head], model_func[model_head]);
                model_valid[model_head] = 1'b0;
                model_ready[model_head] = 1'b0;
                model_head = step(model_head, 1);
                model_count--;
            end
            next_cycle();
        end
        commit_count = '0;
        while (head != tail) begin
            mem_stall = stall && rand_below(2) == 1;
            next_cycle();
        end
        mem_stall = 1'b0;
        check_idx("head", head, model_tail);
        check_idx("tail", tail, model_tail);
    endtask

    task automatic sweep_memory();
        load_tail_store = tail;
        load_func       = mem_word;
        load_check      = 1'b1;
        for (int a = 0; a < dcache_words; a++) begin
            load_addr = addr_t'(4 * a);
            next_cycle();
        end
        load_check = 1'b0;
    endtask

    initial begin
        int order [sq_len];
        int j;
        int swap;
        clock = 1'b0;
        reset = 1'b1;
        alloc_valid = '0;
        alloc_func = '0;
        exec_valid = '0;
        exec_base = '0;
        exec_imm = '0;
        exec_data = '0;
        exec_idx = '0;
        commit_count = '0;
        mem_stall = 1'b0;
        load_addr = '0;
        load_func = '0;
        load_tail_store = '0;
        load_check = 1'b0;
        seed = 32'ha299_e06a;
        for (int s = 0; s < slots; s++) begin
            model_valid[s] = 1'b0;
            model_ready[s] = 1'b0;
        end
        for (int a = 0; a < dcache_words; a++)
            model_mem[a] = '0;
        model_head = '0;
        model_tail = '0;
        model_count = 0;

        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        check_idx("head", head, '0);
        check_idx("tail", tail, '0);
        check_idx("tail_ready", tail_ready, '0);
        check_bit("almost_full", almost_full, 1'b0);
        check_bit("load_forwarded", load_forwarded, 1'b0);

        // First round executes pairs in order and drains without stalls
        fill_queue();
        for (int k = 0; k < model_count; k += 2) begin
            set_port(0, step(model_head, k));
            if (k + 1 < model_count)
                set_port(1, step(model_head, k + 1));
            finish_execute();
        end
        check_idx("tail_ready", tail_ready, expect_tail_ready());
        commit_and_drain(1'b0);
        sweep_memory();

        // Second round starts near the wrap point and executes out of order
        fill_queue();
        forward_loads(8);
        for (int k = 0; k < model_count; k++)
            order[k] = k;
        for (int k = model_count - 1; k > 0; k--) begin
            j = int'(rand_below(k + 1));
            swap = order[k];
            order[k] = order[j];
            order[j] = swap;
        end
        for (int k = 0; k < model_count; k++) begin
            set_port(k % store_ports, step(model_head, order[k]));
            finish_execute();
            check_idx("tail_ready", tail_ready, expect_tail_ready());
        end
        forward_loads(40);
        commit_and_drain(1'b1);
        sweep_memory();

        if (store_subsystem_i.store_queue_i.queue_checker_i.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("The queue checker saw failing assertions");
            $display("Simulation FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// ==== sources.f ====
logic/sq_pkg.sv
logic/store_queue.sv
logic/store_forward.sv
logic/commit_tracker.sv
logic/dcache_store_port.sv
logic/store_subsystem.sv
testbench/store_subsystem_checker.sv
testbench/store_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the store subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module store_subsystem_tb -o store_subsystem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/store_subsystem_sim 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
